// ==== verilog/approx_mul_pkg.sv ====
package approx_mul_pkg;

    // datapath widths.
    localparam int operand_width = 8;
    localparam int product_width = 16;

    // accumulator wraps at this width.
    localparam int acc_width = 24;

    // approximate low bits of each adder.
    // lo is the cross-product adder, hi is the recombining adder.
    localparam int approx_bits_8_lo = 0;
    localparam int approx_bits_8_hi = 5;

    localparam int approx_bits_6_lo = 0;
    localparam int approx_bits_6_hi = 1;

    localparam int approx_bits_4_lo = 0;
    localparam int approx_bits_4_hi = 0;

    // config write data fields.
    localparam int cfg_acc_en_bit = 0;
    localparam int cfg_clear_bit = 1;

endpackage

// ==== verilog/lower_or_adder.sv ====
`timescale 1ns/10ps

module lower_or_adder #(
    parameter int a_width = 8,
    parameter int b_width = 8,
    parameter int or_bits = 0,
    localparam int in_width = (a_width > b_width) ? a_width : b_width
) (
    input  logic [a_width-1:0] x,
    input  logic [b_width-1:0] y,
    output logic [in_width:0]  sum
);
    logic [in_width-1:0] x_ext;
    logic [in_width-1:0] y_ext;

    // narrower input is zero extended.
    assign x_ext = in_width'(x);
    assign y_ext = in_width'(y);

    generate
        if (or_bits == 0) begin : g_exact
            assign sum = x_ext + y_ext;
        end else begin : g_lower_or
            logic [in_width-or_bits:0] upper;

            // upper part gets no carry from the or region.
            assign upper = x_ext[in_width-1:or_bits] + y_ext[in_width-1:or_bits];
            assign sum = {upper, x_ext[or_bits-1:0] | y_ext[or_bits-1:0]};
        end
    endgenerate

endmodule

// ==== verilog/small_array_mult.sv ====
`timescale 1ns/10ps

module small_array_mult #(
    parameter int a_width = 2,
    parameter int b_width = 2,
    localparam int p_width = (a_width == 1) ? b_width :
                             (b_width == 1) ? a_width : a_width + b_width
) (
    input  logic [a_width-1:0] x,
    input  logic [b_width-1:0] y,
    output logic [p_width-1:0] p
);
    logic [a_width+b_width-1:0] partial_sum;

    // one and-row per multiplier bit, shifted and summed.
    always_comb begin
        partial_sum = '0;
        for (int i = 0; i < b_width; i++) begin
            partial_sum = partial_sum + ((a_width + b_width)'(x & {a_width{y[i]}}) << i);
        end
    end

    // a 1-bit factor cannot widen the product.
    assign p = partial_sum[p_width-1:0];

endmodule

// ==== verilog/recursive_mult_4x4.sv ====
`timescale 1ns/10ps

module recursive_mult_4x4 import approx_mul_pkg::*; (
    input  logic [3:0] a,
    input  logic [3:0] b,
    output logic [7:0] p
);
    logic       a_hi;
    logic       b_hi;
    logic [2:0] a_lo;
    logic [2:0] b_lo;
    logic       p_hh;
    logic [2:0] p_hl;
    logic [2:0] p_lh;
    logic [5:0] p_ll;
    logic [3:0] operand1;
    logic [3:0] operand2;
    logic [4:0] total;

    // split 1/3.
    assign a_hi = a[3];
    assign b_hi = b[3];
    assign a_lo = a[2:0];
    assign b_lo = b[2:0];

    small_array_mult #(.a_width(1), .b_width(1)) u_mult_hh (.x(a_hi), .y(b_hi), .p(p_hh));
    small_array_mult #(.a_width(1), .b_width(3)) u_mult_hl (.x(a_hi), .y(b_lo), .p(p_hl));
    small_array_mult #(.a_width(3), .b_width(1)) u_mult_lh (.x(a_lo), .y(b_hi), .p(p_lh));
    small_array_mult #(.a_width(3), .b_width(3)) u_mult_ll (.x(a_lo), .y(b_lo), .p(p_ll));

    // high product sits above the upper half of the low product.
    assign operand1 = {p_hh, p_ll[5:3]};

    lower_or_adder #(
        .a_width(3),
        .b_width(3),
        .or_bits(approx_bits_4_lo)
    ) u_add_cross (
        .x(p_hl),
        .y(p_lh),
        .sum(operand2)
    );

    lower_or_adder #(
        .a_width(4),
        .b_width(4),
        .or_bits(approx_bits_4_hi)
    ) u_add_final (
        .x(operand1),
        .y(operand2),
        .sum(total)
    );

    assign p = {total, p_ll[2:0]};

endmodule

// ==== verilog/recursive_mult_6x6.sv ====
`timescale 1ns/10ps

module recursive_mult_6x6 import approx_mul_pkg::*; (
    input  logic [5:0]  a,
    input  logic [5:0]  b,
    output logic [11:0] p
);
    logic [1:0] a_hi;
    logic [1:0] b_hi;
    logic [3:0] a_lo;
    logic [3:0] b_lo;
    logic [3:0] p_hh;
    logic [5:0] p_hl;
    logic [5:0] p_lh;
    logic [7:0] p_ll;
    logic [7:0] operand1;
    logic [6:0] operand2;
    logic [8:0] total;

    // split 2/4.
    assign a_hi = a[5:4];
    assign b_hi = b[5:4];
    assign a_lo = a[3:0];
    assign b_lo = b[3:0];

    small_array_mult #(.a_width(2), .b_width(2)) u_mult_hh (.x(a_hi), .y(b_hi), .p(p_hh));
    small_array_mult #(.a_width(2), .b_width(4)) u_mult_hl (.x(a_hi), .y(b_lo), .p(p_hl));
    small_array_mult #(.a_width(4), .b_width(2)) u_mult_lh (.x(a_lo), .y(b_hi), .p(p_lh));

    // low x low goes through the next recursion level.
    recursive_mult_4x4 u_mult_ll (.a(a_lo), .b(b_lo), .p(p_ll));

    assign operand1 = {p_hh, p_ll[7:4]};

    lower_or_adder #(
        .a_width(6),
        .b_width(6),
        .or_bits(approx_bits_6_lo)
    ) u_add_cross (
        .x(p_hl),
        .y(p_lh),
        .sum(operand2)
    );

    lower_or_adder #(
        .a_width(8),
        .b_width(7),
        .or_bits(approx_bits_6_hi)
    ) u_add_final (
        .x(operand1),
        .y(operand2),
        .sum(total)
    );

    // total[8] is never set: approximate terms never exceed the exact ones.
    assign p = {total[7:0], p_ll[3:0]};

endmodule

// ==== verilog/recursive_mult_8x8.sv ====
`timescale 1ns/10ps

module recursive_mult_8x8 import approx_mul_pkg::*; (
    input  logic [operand_width-1:0] a,
    input  logic [operand_width-1:0] b,
    output logic [product_width-1:0] p
);
    logic [5:0]  a_hi;
    logic [5:0]  b_hi;
    logic [1:0]  a_lo;
    logic [1:0]  b_lo;
    logic [11:0] p_hh;
    logic [7:0]  p_hl;
    logic [7:0]  p_lh;
    logic [3:0]  p_ll;
    logic [13:0] operand1;
    logic [8:0]  operand2;
    logic [14:0] total;

    // split 6/2, the wide part recurses.
    assign a_hi = a[7:2];
    assign b_hi = b[7:2];
    assign a_lo = a[1:0];
    assign b_lo = b[1:0];

    recursive_mult_6x6 u_mult_hh (.a(a_hi), .b(b_hi), .p(p_hh));

    small_array_mult #(.a_width(6), .b_width(2)) u_mult_hl (.x(a_hi), .y(b_lo), .p(p_hl));
    small_array_mult #(.a_width(2), .b_width(6)) u_mult_lh (.x(a_lo), .y(b_hi), .p(p_lh));
    small_array_mult #(.a_width(2), .b_width(2)) u_mult_ll (.x(a_lo), .y(b_lo), .p(p_ll));

    assign operand1 = {p_hh, p_ll[3:2]};

    lower_or_adder #(
        .a_width(8),
        .b_width(8),
        .or_bits(approx_bits_8_lo)
    ) u_add_cross (
        .x(p_hl),
        .y(p_lh),
        .sum(operand2)
    );

    // five or'ed low bits here dominate the product error.
    lower_or_adder #(
        .a_width(14),
        .b_width(9),
        .or_bits(approx_bits_8_hi)
    ) u_add_final (
        .x(operand1),
        .y(operand2),
        .sum(total)
    );

    // result fits in 16 bits, so the adder carry out stays clear.
    assign p = {total[13:0], p_ll[1:0]};

endmodule

// ==== verilog/mac_config_regs.sv ====
`timescale 1ns/10ps

module mac_config_regs import approx_mul_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cfg_we,
    input  logic [1:0] cfg_wdata,
    output logic       acc_en,
    output logic       acc_clear
);
    logic clear_req;

    assign clear_req = cfg_we && cfg_wdata[cfg_clear_bit];

    // enable level, updated only on a write.
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_en <= 1'b0;
        end else if (cfg_we) begin
            acc_en <= cfg_wdata[cfg_acc_en_bit];
        end
    end

    // clear is a single-cycle pulse per write.
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_clear <= 1'b0;
        end else begin
            acc_clear <= clear_req;
        end
    end

endmodule

// ==== verilog/mac_datapath.sv ====
`timescale 1ns/10ps

module mac_datapath import approx_mul_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  logic [operand_width-1:0] a,
    input  logic [operand_width-1:0] b,
    input  logic                     acc_en,
    input  logic                     acc_clear,
    output logic [product_width-1:0] product,
    output logic                     product_valid,
    output logic [acc_width-1:0]     acc
);
    logic [operand_width-1:0] a_q;
    logic [operand_width-1:0] b_q;
    logic                     operand_valid;
    logic [product_width-1:0] product_d;

    // stage 1 operand capture.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            a_q <= a;
            b_q <= b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            operand_valid <= 1'b0;
        end else begin
            operand_valid <= in_valid;
        end
    end

    recursive_mult_8x8 u_mult (
        .a(a_q),
        .b(b_q),
        .p(product_d)
    );

    // stage 2 product register.
    always_ff @(posedge clk) begin
        if (rst) begin
            product       <= '0;
            product_valid <= 1'b0;
        end else begin
            product_valid <= operand_valid;
            if (operand_valid) begin
                product <= product_d;
            end
        end
    end

    // accumulate on the same edge the product is registered.
    // clear wins over an accumulation.
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (acc_clear) begin
            acc <= '0;
        end else if (operand_valid && acc_en) begin
            acc <= acc + acc_width'(product_d);
        end
    end

endmodule

// ==== verilog/approx_mac_top.sv ====
`timescale 1ns/10ps

module approx_mac_top import approx_mul_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  logic [operand_width-1:0] a,
    input  logic [operand_width-1:0] b,
    input  logic                     cfg_we,
    input  logic [1:0]               cfg_wdata,
    output logic                     cfg_acc_en,
    output logic [product_width-1:0] product,
    output logic                     product_valid,
    output logic [acc_width-1:0]     acc
);
    logic acc_clear;

    mac_config_regs u_config (
        .clk(clk),
        .rst(rst),
        .cfg_we(cfg_we),
        .cfg_wdata(cfg_wdata),
        .acc_en(cfg_acc_en),
        .acc_clear(acc_clear)
    );

    // enable level is also visible at the top.
    mac_datapath u_datapath (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .a(a),
        .b(b),
        .acc_en(cfg_acc_en),
        .acc_clear(acc_clear),
        .product(product),
        .product_valid(product_valid),
        .acc(acc)
    );

endmodule

// ==== sim/approx_mac_tb.sv ====
`timescale 1ns/10ps

module approx_mac_tb import approx_mul_pkg::*; ();

    typedef struct packed {
        logic                     valid;
        logic [operand_width-1:0] a;
        logic [operand_width-1:0] b;
        logic                     we;
        logic [1:0]               wdata;
        logic                     exp_en;
    } row_t;

    logic                     clk;
    logic                     rst;
    logic                     in_valid;
    logic [operand_width-1:0] a;
    logic [operand_width-1:0] b;
    logic                     cfg_we;
    logic [1:0]               cfg_wdata;
    logic                     cfg_acc_en;
    logic [product_width-1:0] product;
    logic                     product_valid;
    logic [acc_width-1:0]     acc;

    row_t                     rows[$];
    logic [product_width-1:0] exp_products[$];
    int                       exp_edges[$];
    logic                     build_en;
    int                       edge_count;
    int                       cycle_count;
    int                       cycle_limit;

    // reference state, as it stands before the next rising edge.
    logic                     m_en;
    logic                     m_clear;
    logic                     m_s1_valid;
    logic [product_width-1:0] m_s1_prod;
    logic [acc_width-1:0]     m_acc;

    approx_mac_top dut (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .a(a),
        .b(b),
        .cfg_we(cfg_we),
        .cfg_wdata(cfg_wdata),
        .cfg_acc_en(cfg_acc_en),
        .product(product),
        .product_valid(product_valid),
        .acc(acc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("Done: errors found");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
                report_failure("timeout, the run took more cycles than the test allows");
            end
        end
    end

    // the low k bits are or'ed, the rest is an exact sum.
    function automatic int unsigned lor_add(input int unsigned x, input int unsigned y,
                                            input int k);
        int unsigned mask;
        mask = (32'd1 << k) - 1;
        return (((x >> k) + (y >> k)) << k) | ((x | y) & mask);
    endfunction

    function automatic int unsigned recombine(input int unsigned hh, input int unsigned hl,
                                              input int unsigned lh, input int unsigned ll,
                                              input int l, input int k_lo, input int k_hi);
        int unsigned op1;
        int unsigned op2;
        int unsigned total;
        op1 = (hh << l) | (ll >> l);
        op2 = lor_add(hl, lh, k_lo);
        total = lor_add(op1, op2, k_hi);
        return (total << l) | (ll & ((32'd1 << l) - 1));
    endfunction

    function automatic int unsigned model_4x4(input int unsigned x, input int unsigned y);
        return recombine((x >> 3) * (y >> 3), (x >> 3) * (y & 7), (x & 7) * (y >> 3),
                         (x & 7) * (y & 7), 3, approx_bits_4_lo, approx_bits_4_hi);
    endfunction

    function automatic int unsigned model_6x6(input int unsigned x, input int unsigned y);
        return recombine((x >> 4) * (y >> 4), (x >> 4) * (y & 15), (x & 15) * (y >> 4),
                         model_4x4(x & 15, y & 15), 4, approx_bits_6_lo, approx_bits_6_hi);
    endfunction

    function automatic logic [product_width-1:0] model_8x8(input int unsigned x,
                                                           input int unsigned y);
        return product_width'(recombine(model_6x6(x >> 2, y >> 2), (x >> 2) * (y & 3),
                                        (x & 3) * (y >> 2), (x & 3) * (y & 3), 2,
                                        approx_bits_8_lo, approx_bits_8_hi));
    endfunction

    task automatic add_row(input logic valid, input int unsigned x, input int unsigned y,
                           input logic we, input logic [1:0] wdata);
        row_t r;
        if (we) begin
            build_en = wdata[cfg_acc_en_bit];
        end
        r.valid = valid;
        r.a = operand_width'(x);
        r.b = operand_width'(y);
        r.we = we;
        r.wdata = wdata;
        r.exp_en = build_en;
        rows.push_back(r);
    endtask

    task automatic build_table();
        build_en = 1'b0;
        add_row(1'b0, 0, 0, 1'b1, 2'b01);
        add_row(1'b1, 0, 0, 1'b0, 2'b00);
        add_row(1'b1, 0, 255, 1'b0, 2'b00);
        add_row(1'b1, 1, 1, 1'b0, 2'b00);
        add_row(1'b1, 1, 255, 1'b0, 2'b00);
        add_row(1'b1, 3, 3, 1'b0, 2'b00);
        add_row(1'b1, 255, 1, 1'b0, 2'b00);
        add_row(1'b1, 255, 255, 1'b0, 2'b00);
        add_row(1'b1, 128, 128, 1'b0, 2'b00);
        add_row(1'b1, 128, 255, 1'b0, 2'b00);
        add_row(1'b1, 85, 170, 1'b0, 2'b00);
        add_row(1'b1, 170, 85, 1'b0, 2'b00);
        add_row(1'b0, 0, 0, 1'b0, 2'b00);
        for (int i = 0; i < 60; i++) begin
            add_row(1'b1, $urandom() & 8'hff, $urandom() & 8'hff, 1'b0, 2'b00);
        end
        // accumulator must hold while disabled.
        add_row(1'b1, $urandom() & 8'hff, $urandom() & 8'hff, 1'b1, 2'b00);
        for (int i = 0; i < 10; i++) begin
            add_row(1'b1, $urandom() & 8'hff, $urandom() & 8'hff, 1'b0, 2'b00);
        end
        add_row(1'b1, 200, 199, 1'b1, 2'b01);
        add_row(1'b1, 250, 251, 1'b0, 2'b00);
        // clear lands on the edge that registers this row's product.
        add_row(1'b1, 255, 255, 1'b1, 2'b11);
        add_row(1'b1, 77, 91, 1'b0, 2'b00);
        add_row(1'b1, 13, 240, 1'b0, 2'b00);
        add_row(1'b0, 0, 0, 1'b1, 2'b10);
        for (int i = 0; i < 4; i++) begin
            add_row(1'b0, 0, 0, 1'b0, 2'b00);
        end
    endtask

    task automatic step_row(input row_t r);
        in_valid = r.valid;
        a = r.a;
        b = r.b;
        cfg_we = r.we;
        cfg_wdata = r.wdata;
        if (m_clear) begin
            m_acc = '0;
        end else if (m_s1_valid && m_en) begin
            m_acc = m_acc + acc_width'(m_s1_prod);
        end
        m_clear = r.we && r.wdata[cfg_clear_bit];
        m_en = r.exp_en;
        m_s1_valid = r.valid;
        m_s1_prod = model_8x8(r.a, r.b);
        if (r.valid) begin
            exp_products.push_back(m_s1_prod);
            exp_edges.push_back(edge_count + 1);
        end
        @(posedge clk);
        edge_count++;
        @(negedge clk);
        check_value("cfg_acc_en", cfg_acc_en, m_en);
        check_value("acc", acc, m_acc);
        if (product_valid) begin
            if (exp_products.size() == 0) begin
                report_failure("product_valid rose with no operand pair outstanding");
            end else begin
                check_value("product", product, exp_products.pop_front());
                check_value("product latency", edge_count - exp_edges.pop_front() + 1, 2);
            end
        end else if (exp_products.size() != 0 && exp_edges[0] + 1 <= edge_count) begin
            report_failure("product_valid did not rise two edges after in_valid");
        end
    endtask

    initial begin
        void'($urandom(32'h5778));
        rst = 1'b1;
        in_valid = 1'b0;
        a = '0;
        b = '0;
        cfg_we = 1'b0;
        cfg_wdata = '0;
        cycle_limit = 0;
        edge_count = 0;
        build_table();
        cycle_limit = rows.size() * 4 + 50;

        // these pairs put no bits into any or region.
        check_value("exact 0x255", model_8x8(0, 255), 0);
        check_value("exact 1x1", model_8x8(1, 1), 1);
        check_value("exact 1x255", model_8x8(1, 255), 255);
        check_value("exact 3x3", model_8x8(3, 3), 9);
        check_value("exact 255x1", model_8x8(255, 1), 255);
        check_value("exact 128x128", model_8x8(128, 128), 16384);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("product_valid", product_valid, 0);
        check_value("product", product, 0);
        check_value("acc", acc, 0);
        check_value("cfg_acc_en", cfg_acc_en, 0);

        m_en = 1'b0;
        m_clear = 1'b0;
        m_s1_valid = 1'b0;
        m_s1_prod = '0;
        m_acc = '0;
        foreach (rows[i]) begin
            step_row(rows[i]);
        end

        if (exp_products.size() != 0) begin
            report_failure("products still outstanding at the end of the run");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// ==== list.f ====
verilog/approx_mul_pkg.sv
verilog/lower_or_adder.sv
verilog/small_array_mult.sv
verilog/recursive_mult_4x4.sv
verilog/recursive_mult_6x6.sv
verilog/recursive_mult_8x8.sv
verilog/mac_config_regs.sv
verilog/mac_datapath.sv
verilog/approx_mac_top.sv
sim/approx_mac_tb.sv
